// ==== tomasuloPkg.sv ====
// Assumes tag 0 is reserved for ready values and station tags stay packed from 1 upward.
package tomasuloPkg;

	localparam int dataWidth = 8;
	localparam int numRegs = 4;
	localparam int regIdxWidth = 2;
	localparam int tagWidth = 3;
	localparam int instrWidth = 16;

	localparam int addEntries = 3;
	localparam int mulEntries = 2;
	localparam int addBaseTag = 1; // add stations own tags 1..3
	localparam int mulBaseTag = 4; // mul stations own tags 4..5

	localparam logic [tagWidth-1:0] noTag = '0;

	localparam int divSteps = 8; // one quotient bit per step

	// only the low two opcode values of each unit are legal
	typedef enum logic [3:0] {
		opAdd = 4'd0,
		opSub = 4'd1,
		opMul = 4'd2,
		opDiv = 4'd3
	} opcodeT;

	// register i comes out of reset holding i+1
	function automatic logic [dataWidth-1:0] regResetValue(input int idx);
		return dataWidth'(idx + 1);
	endfunction

endpackage

// ==== issueStage.sv ====
// Source must hold instr while issueStall is high; illegal opcodes are consumed without effect.
`timescale 1ns/1ps

module issueStage import tomasuloPkg::*; (
	input  logic                   clock,
	input  logic                   rstN,
	input  logic                   instrValid,
	input  logic [instrWidth-1:0]  instr,
	input  logic                   addFull,
	input  logic                   mulFull,
	input  logic [tagWidth-1:0]    addAllocTag,
	input  logic [tagWidth-1:0]    mulAllocTag,
	input  logic                   cdbValid,
	input  logic [tagWidth-1:0]    cdbTag,
	input  logic [dataWidth-1:0]   cdbValue,
	input  logic [regIdxWidth-1:0] readAddr,
	output logic                   issueStall,
	output logic                   addIssue,
	output logic                   mulIssue,
	output opcodeT                 issueOp,
	output logic [dataWidth-1:0]   srcAValue,
	output logic [tagWidth-1:0]    srcATag,
	output logic [dataWidth-1:0]   srcBValue,
	output logic [tagWidth-1:0]    srcBTag,
	output logic [dataWidth-1:0]   readData
);

	logic [dataWidth-1:0] regFile [numRegs];
	logic [tagWidth-1:0] statusTag [numRegs];

	opcodeT opcode;
	logic isAddOp;
	logic isMulOp;
	logic accept;
	logic [regIdxWidth-1:0] dest;
	logic [regIdxWidth-1:0] srcA;
	logic [regIdxWidth-1:0] srcB;
	logic bypassA;
	logic bypassB;
	logic [tagWidth-1:0] newTag;

	// field decode, upper bits of register fields ignored
	assign opcode = opcodeT'(instr[instrWidth-1 -: 4]);
	assign dest = instr[8 +: regIdxWidth];
	assign srcA = instr[4 +: regIdxWidth];
	assign srcB = instr[0 +: regIdxWidth];

	assign isAddOp = (opcode == opAdd) || (opcode == opSub);
	assign isMulOp = (opcode == opMul) || (opcode == opDiv);

	assign issueStall = instrValid && ((isAddOp && addFull) || (isMulOp && mulFull));
	assign accept = instrValid && !issueStall; // illegal ops accepted and dropped

	assign addIssue = accept && isAddOp;
	assign mulIssue = accept && isMulOp;
	assign issueOp = opcode;

	// a result on the bus this cycle resolves a pending operand directly
	assign bypassA = cdbValid && (statusTag[srcA] != noTag) && (statusTag[srcA] == cdbTag);
	assign bypassB = cdbValid && (statusTag[srcB] != noTag) && (statusTag[srcB] == cdbTag);

	assign srcAValue = bypassA ? cdbValue : regFile[srcA];
	assign srcATag = bypassA ? noTag : statusTag[srcA];
	assign srcBValue = bypassB ? cdbValue : regFile[srcB];
	assign srcBTag = bypassB ? noTag : statusTag[srcB];

	assign newTag = addIssue ? addAllocTag : mulAllocTag;

	assign readData = regFile[readAddr]; // architectural read-back

	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int r = 0; r < numRegs; r++) begin
				regFile[r] <= regResetValue(r);
				statusTag[r] <= noTag;
			end
		end else begin
			for (int r = 0; r < numRegs; r++) begin
				// only the latest writer of a register may update it
				if (cdbValid && (statusTag[r] == cdbTag)) begin
					regFile[r] <= cdbValue;
					statusTag[r] <= noTag;
				end
				if ((addIssue || mulIssue) && (dest == regIdxWidth'(r))) begin
					statusTag[r] <= newTag; // rename wins over clear
				end
			end
		end
	end

endmodule

// ==== resStation.sv ====
// Entry i owns tag baseTag+i; tags of all stations must be distinct and nonzero.
`timescale 1ns/1ps

module resStation import tomasuloPkg::*; #(
	parameter int numEntries = addEntries,
	parameter int baseTag = addBaseTag
) (
	input  logic                 clock,
	input  logic                 rstN,
	input  logic                 issue,
	input  opcodeT               issueOp,
	input  logic [dataWidth-1:0] srcAValue,
	input  logic [tagWidth-1:0]  srcATag,
	input  logic [dataWidth-1:0] srcBValue,
	input  logic [tagWidth-1:0]  srcBTag,
	input  logic                 cdbValid,
	input  logic [tagWidth-1:0]  cdbTag,
	input  logic [dataWidth-1:0] cdbValue,
	input  logic                 unitBusy,
	output logic                 full,
	output logic [tagWidth-1:0]  allocTag,
	output logic                 occupied,
	output logic                 start,
	output opcodeT               startOp,
	output logic [dataWidth-1:0] startA,
	output logic [dataWidth-1:0] startB,
	output logic [tagWidth-1:0]  startTag
);

	logic entryBusy [numEntries];
	logic entryDispatched [numEntries];
	opcodeT entryOp [numEntries];
	logic [dataWidth-1:0] entryA [numEntries];
	logic [dataWidth-1:0] entryB [numEntries];
	logic [tagWidth-1:0] waitA [numEntries];
	logic [tagWidth-1:0] waitB [numEntries];

	int allocIdx;
	int startIdx;
	logic anyFree;
	logic anyReady;

	// lowest free entry, scanned from the top so the lowest wins
	always_comb begin
		allocIdx = 0;
		anyFree = 1'b0;
		occupied = 1'b0;
		for (int i = numEntries - 1; i >= 0; i--) begin
			occupied = occupied | entryBusy[i];
			if (!entryBusy[i]) begin
				allocIdx = i;
				anyFree = 1'b1;
			end
		end
	end

	// lowest entry with both operands captured and not yet sent
	always_comb begin
		startIdx = 0;
		anyReady = 1'b0;
		for (int i = numEntries - 1; i >= 0; i--) begin
			if (entryBusy[i] && !entryDispatched[i] &&
					(waitA[i] == noTag) && (waitB[i] == noTag)) begin
				startIdx = i;
				anyReady = 1'b1;
			end
		end
	end

	assign full = !anyFree;
	assign allocTag = tagWidth'(baseTag + allocIdx);

	assign start = anyReady && !unitBusy;
	assign startOp = entryOp[startIdx];
	assign startA = entryA[startIdx];
	assign startB = entryB[startIdx];
	assign startTag = tagWidth'(baseTag + startIdx);

	// operand fields
	always_ff @(posedge clock) begin
		for (int i = 0; i < numEntries; i++) begin
			if (cdbValid && (waitA[i] == cdbTag)) begin // wake up A
				entryA[i] <= cdbValue;
				waitA[i] <= noTag;
			end
			if (cdbValid && (waitB[i] == cdbTag)) begin // wake up B
				entryB[i] <= cdbValue;
				waitB[i] <= noTag;
			end
			if (issue && (allocIdx == i)) begin
				entryOp[i] <= issueOp;
				entryA[i] <= srcAValue;
				waitA[i] <= srcATag;
				entryB[i] <= srcBValue;
				waitB[i] <= srcBTag;
			end
		end
	end

	// entry occupancy
	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < numEntries; i++) begin
				entryBusy[i] <= 1'b0;
				entryDispatched[i] <= 1'b0;
			end
		end else begin
			for (int i = 0; i < numEntries; i++) begin
				if (cdbValid && (cdbTag == tagWidth'(baseTag + i))) begin
					entryBusy[i] <= 1'b0; // own result broadcast, tag free again
				end
				if (start && (startIdx == i)) begin
					entryDispatched[i] <= 1'b1;
				end
				if (issue && (allocIdx == i)) begin
					entryBusy[i] <= 1'b1;
					entryDispatched[i] <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== addSubUnit.sv ====
// Accepts start only while idle; the result stays on resultValue until grant is seen.
`timescale 1ns/1ps

module addSubUnit import tomasuloPkg::*; (
	input  logic                 clock,
	input  logic                 rstN,
	input  logic                 start,
	input  opcodeT               startOp,
	input  logic [dataWidth-1:0] startA,
	input  logic [dataWidth-1:0] startB,
	input  logic [tagWidth-1:0]  startTag,
	input  logic                 grant,
	output logic                 unitBusy,
	output logic                 resultValid,
	output logic [tagWidth-1:0]  resultTag,
	output logic [dataWidth-1:0] resultValue
);

	typedef enum logic [1:0] {idle, compute, hold} stateT;

	stateT state;
	opcodeT opReg;
	logic [dataWidth-1:0] aReg;
	logic [dataWidth-1:0] bReg;
	logic [tagWidth-1:0] tagReg;
	logic [dataWidth-1:0] resultReg;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= idle;
		end else begin
			case (state)
				idle: if (start) state <= compute;
				compute: state <= hold;
				hold: if (grant) state <= idle; // wait for the bus
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (start && (state == idle)) begin
			opReg <= startOp;
			aReg <= startA;
			bReg <= startB;
			tagReg <= startTag;
		end
		if (state == compute) begin
			resultReg <= (opReg == opSub) ? aReg - bReg : aReg + bReg; // wraps mod 256
		end
	end

	assign unitBusy = (state != idle);
	assign resultValid = (state == hold);
	assign resultTag = tagReg;
	assign resultValue = resultReg;

endmodule

// ==== mulDivUnit.sv ====
// Unsigned only; MUL keeps the low byte and a zero divisor returns all ones.
`timescale 1ns/1ps

module mulDivUnit import tomasuloPkg::*; (
	input  logic                 clock,
	input  logic                 rstN,
	input  logic                 start,
	input  opcodeT               startOp,
	input  logic [dataWidth-1:0] startA,
	input  logic [dataWidth-1:0] startB,
	input  logic [tagWidth-1:0]  startTag,
	input  logic                 grant,
	output logic                 unitBusy,
	output logic                 resultValid,
	output logic [tagWidth-1:0]  resultTag,
	output logic [dataWidth-1:0] resultValue
);

	typedef enum logic [1:0] {idle, multiply, divide, hold} stateT;

	stateT state;
	logic [$clog2(divSteps)-1:0] stepCount;
	logic [dataWidth-1:0] aReg;
	logic [dataWidth-1:0] bReg;
	logic [tagWidth-1:0] tagReg;
	logic [2*dataWidth-1:0] prodReg;
	logic [dataWidth-1:0] remReg;
	logic [dataWidth-1:0] quotReg;
	logic [dataWidth-1:0] resultReg;

	logic [dataWidth:0] shifted;
	logic [dataWidth:0] trial;
	logic fits;
	logic [dataWidth-1:0] remNext;
	logic [dataWidth-1:0] quotNext;

	// one restoring step: shift in the next dividend bit and try to subtract
	assign shifted = {remReg, quotReg[dataWidth-1]};
	assign trial = shifted - {1'b0, bReg};
	assign fits = !trial[dataWidth];
	assign remNext = fits ? trial[dataWidth-1:0] : shifted[dataWidth-1:0];
	assign quotNext = {quotReg[dataWidth-2:0], fits}; // dividend shifts out as quotient shifts in

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= idle;
			stepCount <= '0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						state <= (startOp == opDiv) ? divide : multiply;
						stepCount <= '0;
					end
				end
				multiply: begin
					stepCount <= stepCount + 1'b1;
					if (stepCount != '0) state <= hold; // second product stage done
				end
				divide: begin
					stepCount <= stepCount + 1'b1;
					if (stepCount == $bits(stepCount)'(divSteps - 1)) state <= hold;
				end
				hold: if (grant) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (start && (state == idle)) begin
			aReg <= startA;
			bReg <= startB;
			tagReg <= startTag;
			quotReg <= startA;
			remReg <= '0;
		end
		if (state == multiply) begin
			if (stepCount == '0) prodReg <= aReg * bReg;
			else resultReg <= prodReg[dataWidth-1:0]; // truncate to low byte
		end
		if (state == divide) begin
			remReg <= remNext;
			quotReg <= quotNext;
			if (stepCount == $bits(stepCount)'(divSteps - 1)) begin
				resultReg <= (bReg == '0) ? '1 : quotNext;
			end
		end
	end

	assign unitBusy = (state != idle);
	assign resultValid = (state == hold);
	assign resultTag = tagReg;
	assign resultValue = resultReg;

endmodule

// ==== cdbArbiter.sv ====
// Requesters must hold valid, tag and value until granted; bus is valid one cycle after grant.
`timescale 1ns/1ps

module cdbArbiter import tomasuloPkg::*; (
	input  logic                 clock,
	input  logic                 rstN,
	input  logic                 addValid,
	input  logic [tagWidth-1:0]  addTag,
	input  logic [dataWidth-1:0] addValue,
	input  logic                 mulValid,
	input  logic [tagWidth-1:0]  mulTag,
	input  logic [dataWidth-1:0] mulValue,
	output logic                 addGrant,
	output logic                 mulGrant,
	output logic                 cdbValid,
	output logic [tagWidth-1:0]  cdbTag,
	output logic [dataWidth-1:0] cdbValue
);

	logic mulFirst; // round-robin pointer, add side after reset

	assign addGrant = addValid && (!mulValid || !mulFirst);
	assign mulGrant = mulValid && (!addValid || mulFirst);

	always_ff @(posedge clock) begin
		if (!rstN) begin
			mulFirst <= 1'b0;
			cdbValid <= 1'b0;
		end else begin
			cdbValid <= addGrant || mulGrant;
			if (addGrant) mulFirst <= 1'b1;
			else if (mulGrant) mulFirst <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (addGrant || mulGrant) begin
			cdbTag <= addGrant ? addTag : mulTag;
			cdbValue <= addGrant ? addValue : mulValue;
		end
	end

endmodule

// ==== tomasuloTop.sv ====
// busy covers occupied stations only; wait for it low before trusting readData.
`timescale 1ns/1ps

module tomasuloTop import tomasuloPkg::*; (
	input  logic                   clock,
	input  logic                   rstN,
	input  logic                   instrValid,
	input  logic [instrWidth-1:0]  instr,
	output logic                   issueStall,
	input  logic [regIdxWidth-1:0] readAddr,
	output logic [dataWidth-1:0]   readData,
	output logic                   cdbValid,
	output logic [tagWidth-1:0]    cdbTag,
	output logic [dataWidth-1:0]   cdbValue,
	output logic                   busy
);

	logic addIssue;
	logic mulIssue;
	opcodeT issueOp;
	logic [dataWidth-1:0] srcAValue;
	logic [tagWidth-1:0] srcATag;
	logic [dataWidth-1:0] srcBValue;
	logic [tagWidth-1:0] srcBTag;

	logic addFull;
	logic mulFull;
	logic [tagWidth-1:0] addAllocTag;
	logic [tagWidth-1:0] mulAllocTag;
	logic addOccupied;
	logic mulOccupied;

	// station to unit dispatch
	logic addStart;
	logic mulStart;
	opcodeT addStartOp;
	opcodeT mulStartOp;
	logic [dataWidth-1:0] addStartA;
	logic [dataWidth-1:0] addStartB;
	logic [dataWidth-1:0] mulStartA;
	logic [dataWidth-1:0] mulStartB;
	logic [tagWidth-1:0] addStartTag;
	logic [tagWidth-1:0] mulStartTag;
	logic addUnitBusy;
	logic mulUnitBusy;

	// unit to bus
	logic addResultValid;
	logic mulResultValid;
	logic [tagWidth-1:0] addResultTag;
	logic [tagWidth-1:0] mulResultTag;
	logic [dataWidth-1:0] addResultValue;
	logic [dataWidth-1:0] mulResultValue;
	logic addGrant;
	logic mulGrant;

	issueStage i_issueStage (
		.clock, .rstN, .instrValid, .instr, .addFull, .mulFull, .addAllocTag, .mulAllocTag,
		.cdbValid, .cdbTag, .cdbValue, .readAddr, .issueStall, .addIssue, .mulIssue,
		.issueOp, .srcAValue, .srcATag, .srcBValue, .srcBTag, .readData
	);

	resStation #(.numEntries(addEntries), .baseTag(addBaseTag)) addStations (
		.clock, .rstN, .issue(addIssue), .issueOp, .srcAValue, .srcATag, .srcBValue, .srcBTag,
		.cdbValid, .cdbTag, .cdbValue, .unitBusy(addUnitBusy), .full(addFull),
		.allocTag(addAllocTag), .occupied(addOccupied), .start(addStart), .startOp(addStartOp),
		.startA(addStartA), .startB(addStartB), .startTag(addStartTag)
	);

	resStation #(.numEntries(mulEntries), .baseTag(mulBaseTag)) mulStations (
		.clock, .rstN, .issue(mulIssue), .issueOp, .srcAValue, .srcATag, .srcBValue, .srcBTag,
		.cdbValid, .cdbTag, .cdbValue, .unitBusy(mulUnitBusy), .full(mulFull),
		.allocTag(mulAllocTag), .occupied(mulOccupied), .start(mulStart), .startOp(mulStartOp),
		.startA(mulStartA), .startB(mulStartB), .startTag(mulStartTag)
	);

	addSubUnit i_addSubUnit (
		.clock, .rstN, .start(addStart), .startOp(addStartOp), .startA(addStartA),
		.startB(addStartB), .startTag(addStartTag), .grant(addGrant), .unitBusy(addUnitBusy),
		.resultValid(addResultValid), .resultTag(addResultTag), .resultValue(addResultValue)
	);

	mulDivUnit i_mulDivUnit (
		.clock, .rstN, .start(mulStart), .startOp(mulStartOp), .startA(mulStartA),
		.startB(mulStartB), .startTag(mulStartTag), .grant(mulGrant), .unitBusy(mulUnitBusy),
		.resultValid(mulResultValid), .resultTag(mulResultTag), .resultValue(mulResultValue)
	);

	cdbArbiter i_cdbArbiter (
		.clock, .rstN, .addValid(addResultValid), .addTag(addResultTag),
		.addValue(addResultValue), .mulValid(mulResultValid), .mulTag(mulResultTag),
		.mulValue(mulResultValue), .addGrant, .mulGrant, .cdbValid, .cdbTag, .cdbValue
	);

	assign busy = addOccupied || mulOccupied;

endmodule

// ==== tomasuloTb.sv ====
// Drives whole programs into the core and checks registers only once busy falls; fixed seed.
`timescale 1ns/1ps

module tomasuloTb import tomasuloPkg::*; ();

	localparam int halfPeriod = 4;
	localparam int resetCycles = 16;
	localparam int directedLength = 28; // add/sub 5, chains 6, div 6, burst 11
	localparam int randomLength = 200;
	localparam int watchdogCycles = 40 * (directedLength + randomLength) + 1000;

	logic clock;
	logic rstN;
	logic instrValid;
	logic [instrWidth-1:0] instr;
	logic issueStall;
	logic [regIdxWidth-1:0] readAddr;
	logic [dataWidth-1:0] readData;
	logic cdbValid;
	logic [tagWidth-1:0] cdbTag;
	logic [dataWidth-1:0] cdbValue;
	logic busy;

	logic [dataWidth-1:0] modelRegs [numRegs]; // in-order architectural state
	logic [dataWidth-1:0] pendingResults [$]; // results still owed on the bus
	logic [instrWidth-1:0] instrList [$];
	int valueErrors = 0;
	int otherErrors = 0;
	int stallCount = 0;
	int busPulses = 0;
	bit watchBus = 1'b0;

	tomasuloTop i_tomasuloTop (
		.clock, .rstN, .instrValid, .instr, .issueStall, .readAddr, .readData,
		.cdbValid, .cdbTag, .cdbValue, .busy
	);

	initial clock = 1'b0;
	always #halfPeriod clock = ~clock;

	function automatic logic [instrWidth-1:0] makeInstr(input logic [3:0] op, input int d,
			input int a, input int b);
		return {op, 2'b00, 2'(d), 2'b00, 2'(a), 2'b00, 2'(b)};
	endfunction

	// result of one operation by the arithmetic rules
	function automatic logic [dataWidth-1:0] expectedResult(input logic [3:0] op,
			input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		logic [2*dataWidth-1:0] product;
		product = a * b;
		case (op)
			4'd0: return a + b; // wraps
			4'd1: return a - b;
			4'd2: return product[dataWidth-1:0]; // low byte only
			4'd3: return (b == '0) ? '1 : a / b;
			default: return '0;
		endcase
	endfunction

	// sequential execution, illegal opcodes do nothing
	function automatic void applyReference(input logic [instrWidth-1:0] ins);
		logic [dataWidth-1:0] result;
		if (ins[15:12] <= 4'd3) begin
			result = expectedResult(ins[15:12], modelRegs[ins[5:4]], modelRegs[ins[1:0]]);
			modelRegs[ins[9:8]] = result;
			pendingResults.push_back(result); // one broadcast per legal op
		end
	endfunction

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic offerInstr(input logic [instrWidth-1:0] ins);
		bit accepted;
		accepted = 1'b0;
		instrValid = 1'b1;
		instr = ins;
		while (!accepted) begin
			#1;
			if (issueStall) stallCount++; // held for another cycle
			else accepted = 1'b1;
			@(negedge clock);
		end
	endtask

	task automatic expectLow(input string name, input logic value);
		assert (value === 1'b0) else begin
			valueErrors++;
			$display("Fail at %0t ns: %s expected 0 actual %b", $time, name, value);
		end
	endtask

	// broadcasts may come out of order, so any owed result may match
	task automatic matchBroadcast(input logic [dataWidth-1:0] value);
		int hit;
		hit = -1;
		foreach (pendingResults[i]) begin
			if ((hit < 0) && (pendingResults[i] === value)) hit = i;
		end
		assert (hit >= 0) else begin
			if (pendingResults.size() == 0) begin
				otherErrors++;
				$display("a broadcast of %0d appeared on the bus with no result owed", value);
			end else begin
				valueErrors++;
				$display("Fail at %0t ns: cdbValue expected one of %0d owed, oldest %0d, actual %0d",
					$time, pendingResults.size(), pendingResults[0], value);
			end
		end
		if (hit >= 0) pendingResults.delete(hit);
	endtask

	task automatic checkRegisters();
		for (int r = 0; r < numRegs; r++) begin
			@(negedge clock);
			readAddr = regIdxWidth'(r);
			#1;
			assert (readData === modelRegs[r]) else begin
				valueErrors++;
				$display("Fail at %0t ns: R%0d expected %0d actual %0d", $time, r,
					modelRegs[r], readData);
			end
		end
		@(negedge clock);
	endtask

	task automatic runProgram(input bit expectStall);
		int stallsBefore;
		stallsBefore = stallCount;
		foreach (instrList[i]) begin
			applyReference(instrList[i]);
			offerInstr(instrList[i]);
		end
		instrValid = 1'b0;
		while (busy) @(negedge clock); // all stations drained
		assert (pendingResults.size() == 0) else begin
			otherErrors++;
			$display("%0d results never appeared on the bus", pendingResults.size());
		end
		pendingResults.delete();
		checkRegisters();
		if (expectStall) begin
			assert (stallCount > stallsBefore) else begin
				otherErrors++;
				$display("issueStall never rose while the division burst was offered");
			end
		end
		instrList.delete();
	endtask

	// every broadcast must carry an owed value and name a real station
	always @(negedge clock) begin
		if (cdbValid === 1'b1) begin
			matchBroadcast(cdbValue);
		end
		if (watchBus && cdbValid) begin
			busPulses++;
			assert (cdbTag >= 3'd1 && cdbTag <= 3'd5) else begin
				valueErrors++;
				$display("Fail at %0t ns: cdbTag expected 1..5 actual %0d", $time, cdbTag);
			end
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge clock);
		$display("watchdog expired after %0d cycles without the tests finishing", watchdogCycles);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		logic [3:0] op;
		void'($urandom(32'he7f5_cb1f));
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		readAddr = '0;
		for (int r = 0; r < numRegs; r++) modelRegs[r] = dataWidth'(r + 1);
		repeat (resetCycles) @(negedge clock);
		rstN = 1'b1;
		@(negedge clock);
		expectLow("busy", busy);
		expectLow("cdbValid", cdbValid);
		expectLow("issueStall", issueStall);
		checkRegisters();

		instrList.push_back(makeInstr(opSub, 0, 0, 3)); // underflow
		instrList.push_back(makeInstr(opAdd, 1, 2, 3));
		instrList.push_back(makeInstr(opAdd, 2, 0, 0)); // overflow
		instrList.push_back(makeInstr(opSub, 3, 1, 2));
		instrList.push_back(makeInstr(opAdd, 0, 3, 3));
		runProgram(1'b0);

		instrList.push_back(makeInstr(opMul, 1, 1, 3));
		instrList.push_back(makeInstr(opAdd, 0, 1, 2)); // waits on the mul tag
		instrList.push_back(makeInstr(opMul, 3, 0, 1));
		instrList.push_back(makeInstr(opAdd, 3, 2, 2)); // WAW, finishes first
		instrList.push_back(makeInstr(opSub, 2, 3, 0));
		instrList.push_back(makeInstr(opMul, 0, 2, 1));
		runProgram(1'b0);

		instrList.push_back(makeInstr(opDiv, 0, 3, 1));
		instrList.push_back(makeInstr(opSub, 2, 2, 2)); // zero divisor
		instrList.push_back(makeInstr(opDiv, 1, 3, 2));
		instrList.push_back(makeInstr(opMul, 3, 1, 1)); // 255*255 truncated
		instrList.push_back(makeInstr(opMul, 2, 1, 0));
		instrList.push_back(makeInstr(opDiv, 0, 1, 3));
		runProgram(1'b0);

		instrList.push_back(makeInstr(opAdd, 3, 3, 1));
		instrList.push_back(makeInstr(opDiv, 0, 1, 3));
		instrList.push_back(makeInstr(4'd4, 0, 1, 2)); // illegal
		instrList.push_back(makeInstr(opDiv, 1, 0, 3));
		instrList.push_back(makeInstr(opDiv, 2, 1, 0));
		instrList.push_back(makeInstr(4'd15, 3, 3, 3)); // illegal
		instrList.push_back(makeInstr(opDiv, 0, 2, 1));
		instrList.push_back(makeInstr(opDiv, 3, 1, 2));
		instrList.push_back(makeInstr(opAdd, 1, 0, 3));
		instrList.push_back(makeInstr(opSub, 2, 2, 1));
		instrList.push_back(makeInstr(opAdd, 0, 3, 3));
		runProgram(1'b1);

		for (int n = 0; n < randomLength; n++) begin
			op = ($urandom % 10 == 0) ? 4'(4 + $urandom % 12) : 4'($urandom % 4);
			instrList.push_back({op, 12'($urandom)}); // upper field bits random too
		end
		watchBus = 1'b1;
		runProgram(1'b0);
		watchBus = 1'b0;
		assert (busPulses > 0) else begin
			otherErrors++;
			$display("no broadcast was seen on the bus during the random program");
		end

		$display("errors: %0d wrong values, %0d other failures (stalls %0d, bus pulses %0d)",
			valueErrors, otherErrors, stallCount, busPulses);
		if (valueErrors + otherErrors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== project.f ====
tomasuloPkg.sv
issueStage.sv
resStation.sv
addSubUnit.sv
mulDivUnit.sv
cdbArbiter.sv
tomasuloTop.sv
tomasuloTb.sv
